// ==== build.f ====
+incdir+common
common/div_pkg.sv
common/result_wr_if.sv
divider/divider_nr.sv
source/div_dispatch.sv
source/result_arbiter.sv
source/result_store.sv
source/div_cluster.sv
tests/tb_div_cluster.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
TOP       ?= tb_div_cluster
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := STATUS: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/tb_div_cluster.sv ====
`timescale 1ns/1ns

`include "div_defs.svh"

module tb_div_cluster;

  import div_pkg::*;

  localparam int CLK_PERIOD  = 100;
  localparam int NUM_TAGS    = 1 << `DIV_TAG_BITS;
  // All jobs over the whole run including the ignored start.
  localparam int TOTAL_JOBS  = 27;
  localparam int WATCHDOG_NS = TOTAL_JOBS * 100 * CLK_PERIOD;
  localparam int READY_LIMIT = 200;

  logic     clk;
  logic     reset;
  logic     start;
  tag_t     tag;
  operand_t dividend;
  operand_t divisor;
  tag_t     rd_tag;
  logic     ready;
  logic     complete;
  tag_t     complete_tag;
  logic     rd_valid;
  operand_t rd_quotient;
  operand_t rd_remainder;

  // Model of what the result store should hold.
  logic     exp_valid [NUM_TAGS];
  operand_t exp_q [NUM_TAGS];
  operand_t exp_r [NUM_TAGS];

  int   issued_cnt [NUM_TAGS];
  int   comp_cnt [NUM_TAGS];
  int   issued_total;
  int   comp_total;
  int   checks;
  int   errors;

  logic [16:0] lfsr_state;

  div_cluster dut0 (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .tag          (tag),
    .dividend     (dividend),
    .divisor      (divisor),
    .rd_tag       (rd_tag),
    .ready        (ready),
    .complete     (complete),
    .complete_tag (complete_tag),
    .rd_valid     (rd_valid),
    .rd_quotient  (rd_quotient),
    .rd_remainder (rd_remainder)
  );

  initial begin
    clk = 1'b0;
  end

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Completions are sampled mid-cycle, well away from the clock edge.
  always @(negedge clk) begin
    if (!reset && complete) begin
      comp_cnt[complete_tag]++;
      comp_total++;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog: run still going after %0d ns, aborting", WATCHDOG_NS);
    $display("STATUS: FAIL");
    $finish;
  end

  // Fibonacci LFSR with taps for x^17 + x^14 + 1.
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[16] ^ lfsr_state[13];
    lfsr_state = {lfsr_state[15:0], fb};
    return fb;
  endfunction

  function automatic operand_t draw_bits(input int n);
    operand_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[`DIV_BITS-2:0], lfsr_bit()};
    end
    return v;
  endfunction

  // A zero divisor gives ones over every significant bit of the dividend.
  function automatic operand_t ref_quotient(input operand_t dd, input operand_t dv);
    operand_t q;
    q = '0;
    if (dv != '0) begin
      q = dd / dv;
    end else begin
      for (int i = 0; i < `DIV_BITS; i++) begin
        if ((dd >> i) != '0) begin
          q[i] = 1'b1;
        end
      end
    end
    return q;
  endfunction

  function automatic operand_t ref_remainder(input operand_t dd, input operand_t dv);
    if (dv == '0) begin
      return dd;
    end
    return dd % dv;
  endfunction

  task automatic tick();
    @(posedge clk);
    #5;
  endtask

  task automatic idle(input int n);
    repeat (n) tick();
  endtask

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
    checks++;
    assert (got === expected) else begin
      errors++;
      $display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
    end
  endtask

  task automatic clear_counts();
    for (int t = 0; t < NUM_TAGS; t++) begin
      issued_cnt[t] = 0;
      comp_cnt[t]   = 0;
    end
    issued_total = 0;
    comp_total   = 0;
  endtask

  task automatic issue_job(input tag_t t, input operand_t dd, input operand_t dv);
    int waited;
    waited = 0;
    while (!ready && waited < READY_LIMIT) begin
      tick();
      waited++;
    end
    checks++;
    assert (ready) else begin
      errors++;
      $display("Ready never rose within %0d cycles, job for tag %0d dropped",
               READY_LIMIT, t);
    end
    if (ready) begin
      start    = 1'b1;
      tag      = t;
      dividend = dd;
      divisor  = dv;
      exp_valid[t] = 1'b1;
      exp_q[t]     = ref_quotient(dd, dv);
      exp_r[t]     = ref_remainder(dd, dv);
      issued_cnt[t]++;
      issued_total++;
      tick();
      start = 1'b0;
    end
  endtask

  task automatic wait_completions();
    int waited;
    int limit;
    waited = 0;
    limit  = (issued_total + 1) * 100;
    while (comp_total < issued_total && waited < limit) begin
      tick();
      waited++;
    end
    checks++;
    assert (comp_total >= issued_total) else begin
      errors++;
      $display("Only %0d of %0d jobs completed within %0d cycles",
               comp_total, issued_total, limit);
    end
  endtask

  task automatic check_completions();
    for (int t = 0; t < NUM_TAGS; t++) begin
      compare_value($sformatf("completion count of tag %0d", t), comp_cnt[t], issued_cnt[t]);
    end
    compare_value("total completions", comp_total, issued_total);
  endtask

  task automatic read_entry(input tag_t t);
    rd_tag = t;
    tick();
  endtask

  task automatic verify_all();
    for (int t = 0; t < NUM_TAGS; t++) begin
      read_entry(tag_t'(t));
      compare_value($sformatf("valid of tag %0d", t), rd_valid, exp_valid[t]);
      if (exp_valid[t]) begin
        compare_value($sformatf("quotient of tag %0d", t), rd_quotient, exp_q[t]);
        compare_value($sformatf("remainder of tag %0d", t), rd_remainder, exp_r[t]);
      end
    end
  endtask

  task automatic test_reset_state();
    compare_value("ready after reset", ready, 1);
    compare_value("complete after reset", complete, 0);
    verify_all();
  endtask

  task automatic test_single_job();
    clear_counts();
    issue_job(4'd3, 16'd1000, 16'd7);
    wait_completions();
    idle(4);
    check_completions();
    read_entry(4'd3);
    compare_value("valid of 1000/7", rd_valid, 1);
    compare_value("quotient of 1000/7", rd_quotient, 142);
    compare_value("remainder of 1000/7", rd_remainder, 6);
  endtask

  task automatic test_edge_operands();
    clear_counts();
    issue_job(4'd8, 16'd0, 16'd5);
    issue_job(4'd9, 16'd5, 16'd9);
    issue_job(4'd10, 16'hffff, 16'd1);
    issue_job(4'd11, 16'hffff, 16'hffff);
    issue_job(4'd12, 16'd300, 16'd0);
    wait_completions();
    idle(4);
    check_completions();
    verify_all();
  endtask

  task automatic test_random_jobs();
    operand_t dd;
    operand_t dv;
    operand_t shift;
    clear_counts();
    for (int t = 0; t < NUM_TAGS; t++) begin
      shift = draw_bits(4);
      dd    = draw_bits(`DIV_BITS) >> shift;
      shift = draw_bits(4);
      dv    = draw_bits(`DIV_BITS) >> shift;
      issue_job(tag_t'(t), dd, dv);
    end
    wait_completions();
    idle(4);
    check_completions();
    verify_all();
  endtask

  // Both dividends are 12 bits wide. Only the first job ends with an even
  // quotient and needs the final correction, so the later start catches up
  // and both lanes ask for the store in the same cycle.
  task automatic test_back_to_back();
    clear_counts();
    issue_job(4'd6, 16'h0abc, 16'h0013);
    compare_value("ready with one lane busy", ready, 1);
    issue_job(4'd7, 16'h09f1, 16'h002b);
    wait_completions();
    idle(4);
    check_completions();
    verify_all();
  endtask

  task automatic test_start_while_busy();
    clear_counts();
    issue_job(4'd1, 16'hffff, 16'd3);
    issue_job(4'd2, 16'hffff, 16'h0101);
    compare_value("ready with both lanes busy", ready, 0);
    start    = 1'b1;
    tag      = 4'd6;
    dividend = 16'd50;
    divisor  = 16'd5;
    tick();
    start = 1'b0;
    wait_completions();
    idle(20);
    check_completions();
    verify_all();
  endtask

  initial begin
    lfsr_state   = 17'd97567;
    checks       = 0;
    errors       = 0;
    reset        = 1'b1;
    start        = 1'b0;
    tag          = '0;
    dividend     = '0;
    divisor      = '0;
    rd_tag       = '0;
    for (int t = 0; t < NUM_TAGS; t++) begin
      exp_valid[t] = 1'b0;
      exp_q[t]     = '0;
      exp_r[t]     = '0;
    end
    clear_counts();
    idle(4);
    reset = 1'b0;
    tick();

    test_reset_state();
    test_single_job();
    test_edge_operands();
    test_random_jobs();
    test_back_to_back();
    test_start_while_busy();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== source/div_cluster.sv ====
`timescale 1ns/1ns

module div_cluster (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  div_pkg::tag_t     tag,
  input  div_pkg::operand_t dividend,
  input  div_pkg::operand_t divisor,
  input  div_pkg::tag_t     rd_tag,
  output logic              ready,
  output logic              complete,
  output div_pkg::tag_t     complete_tag,
  output logic              rd_valid,
  output div_pkg::operand_t rd_quotient,
  output div_pkg::operand_t rd_remainder
);

  import div_pkg::*;

  logic [1:0] eng_start;
  logic [1:0] eng_done;
  operand_t   eng_dividend [2];
  operand_t   eng_divisor [2];
  operand_t   eng_quotient [2];
  operand_t   eng_remainder [2];
  operand_t   mem_quotient;
  operand_t   mem_remainder;

  result_wr_if wr0_if ();
  result_wr_if wr1_if ();

  div_dispatch u_dispatch (
    .clk           (clk),
    .reset         (reset),
    .start         (start),
    .tag           (tag),
    .dividend      (dividend),
    .divisor       (divisor),
    .ready         (ready),
    .eng_start     (eng_start),
    .eng_dividend  (eng_dividend),
    .eng_divisor   (eng_divisor),
    .eng_done      (eng_done),
    .eng_quotient  (eng_quotient),
    .eng_remainder (eng_remainder),
    .wr0           (wr0_if.lane),
    .wr1           (wr1_if.lane)
  );

  divider_nr u_div0 (
    .clk       (clk),
    .reset     (reset),
    .start     (eng_start[0]),
    .dividend  (eng_dividend[0]),
    .divisor   (eng_divisor[0]),
    .done      (eng_done[0]),
    .quotient  (eng_quotient[0]),
    .remainder (eng_remainder[0])
  );

  divider_nr u_div1 (
    .clk       (clk),
    .reset     (reset),
    .start     (eng_start[1]),
    .dividend  (eng_dividend[1]),
    .divisor   (eng_divisor[1]),
    .done      (eng_done[1]),
    .quotient  (eng_quotient[1]),
    .remainder (eng_remainder[1])
  );

  // A store write is the completion of a job.
  result_arbiter u_arbiter (
    .clk           (clk),
    .reset         (reset),
    .wr0           (wr0_if.arbiter),
    .wr1           (wr1_if.arbiter),
    .mem_we        (complete),
    .mem_tag       (complete_tag),
    .mem_quotient  (mem_quotient),
    .mem_remainder (mem_remainder)
  );

  result_store u_store (
    .clk          (clk),
    .reset        (reset),
    .we           (complete),
    .wr_tag       (complete_tag),
    .wr_quotient  (mem_quotient),
    .wr_remainder (mem_remainder),
    .rd_tag       (rd_tag),
    .rd_valid     (rd_valid),
    .rd_quotient  (rd_quotient),
    .rd_remainder (rd_remainder)
  );

endmodule

// ==== source/result_store.sv ====
`timescale 1ns/1ns

`include "div_defs.svh"

module result_store (
  input  logic              clk,
  input  logic              reset,
  input  logic              we,
  input  div_pkg::tag_t     wr_tag,
  input  div_pkg::operand_t wr_quotient,
  input  div_pkg::operand_t wr_remainder,
  input  div_pkg::tag_t     rd_tag,
  output logic              rd_valid,
  output div_pkg::operand_t rd_quotient,
  output div_pkg::operand_t rd_remainder
);

  import div_pkg::*;

  localparam int DEPTH = 1 << `DIV_TAG_BITS;

  logic [DEPTH-1:0] valid;
  operand_t         q_mem [DEPTH];
  operand_t         r_mem [DEPTH];

  always_ff @(posedge clk) begin
    if (reset) begin
      valid    <= '0;
      rd_valid <= 1'b0;
    end else begin
      if (we) begin
        valid[wr_tag] <= 1'b1;
      end
      rd_valid <= valid[rd_tag];
    end
  end

  always_ff @(posedge clk) begin
    if (we) begin
      q_mem[wr_tag] <= wr_quotient;
      r_mem[wr_tag] <= wr_remainder;
    end
    rd_quotient  <= q_mem[rd_tag];
    rd_remainder <= r_mem[rd_tag];
  end

endmodule

// ==== source/result_arbiter.sv ====
`timescale 1ns/1ns

module result_arbiter (
  input  logic              clk,
  input  logic              reset,
  result_wr_if.arbiter      wr0,
  result_wr_if.arbiter      wr1,
  output logic              mem_we,
  output div_pkg::tag_t     mem_tag,
  output div_pkg::operand_t mem_quotient,
  output div_pkg::operand_t mem_remainder
);

  import div_pkg::*;

  logic [1:0] req;
  logic       any_req;
  lane_t      last;
  lane_t      winner;

  assign req     = {wr1.request, wr0.request};
  assign any_req = |req;

  // With both lanes asking, the one that lost last time goes first.
  always_comb begin
    if (&req) begin
      winner = ~last;
    end else if (req[1]) begin
      winner = 1'b1;
    end else begin
      winner = 1'b0;
    end
  end

  assign wr0.grant = any_req & (winner == 1'b0);
  assign wr1.grant = any_req & (winner == 1'b1);

  // Starts at lane 1 so that lane 0 wins the first contest.
  always_ff @(posedge clk) begin
    if (reset) begin
      last <= 1'b1;
    end else if (any_req) begin
      last <= winner;
    end
  end

  assign mem_we        = any_req;
  assign mem_tag       = winner ? wr1.tag : wr0.tag;
  assign mem_quotient  = winner ? wr1.quotient : wr0.quotient;
  assign mem_remainder = winner ? wr1.remainder : wr0.remainder;

endmodule

// ==== source/div_dispatch.sv ====
`timescale 1ns/1ns

module div_dispatch (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  div_pkg::tag_t     tag,
  input  div_pkg::operand_t dividend,
  input  div_pkg::operand_t divisor,
  output logic              ready,
  output logic [1:0]        eng_start,
  output div_pkg::operand_t eng_dividend [2],
  output div_pkg::operand_t eng_divisor [2],
  input  logic [1:0]        eng_done,
  input  div_pkg::operand_t eng_quotient [2],
  input  div_pkg::operand_t eng_remainder [2],
  result_wr_if.lane         wr0,
  result_wr_if.lane         wr1
);

  import div_pkg::*;

  logic [1:0] busy;
  logic [1:0] pending;
  logic [1:0] free;
  logic [1:0] grant;
  logic       accept;
  lane_t      sel;
  tag_t       lane_tag [2];

  // A lane is free once its engine is idle and its result has been written.
  assign free   = ~busy & ~pending;
  assign ready  = |free;
  assign accept = start & ready;
  assign sel    = free[0] ? 1'b0 : 1'b1;
  assign grant  = {wr1.grant, wr0.grant};

  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= '0;
      pending   <= '0;
      eng_start <= '0;
    end else begin
      eng_start <= '0;
      if (accept) begin
        busy[sel]      <= 1'b1;
        eng_start[sel] <= 1'b1;
      end
      for (int i = 0; i < 2; i++) begin
        if (eng_done[i]) begin
          busy[i]    <= 1'b0;
          pending[i] <= 1'b1;
        end else if (pending[i] && grant[i]) begin
          pending[i] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      lane_tag[sel]     <= tag;
      eng_dividend[sel] <= dividend;
      eng_divisor[sel]  <= divisor;
    end
  end

  // Engine outputs stay put until the lane is restarted.
  assign wr0.request   = pending[0];
  assign wr0.tag       = lane_tag[0];
  assign wr0.quotient  = eng_quotient[0];
  assign wr0.remainder = eng_remainder[0];

  assign wr1.request   = pending[1];
  assign wr1.tag       = lane_tag[1];
  assign wr1.quotient  = eng_quotient[1];
  assign wr1.remainder = eng_remainder[1];

endmodule

// ==== divider/divider_nr.sv ====
`timescale 1ns/1ns

`include "div_defs.svh"

module divider_nr (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  div_pkg::operand_t dividend,
  input  div_pkg::operand_t divisor,
  output logic              done,
  output div_pkg::operand_t quotient,
  output div_pkg::operand_t remainder
);

  import div_pkg::*;

  // Two guard bits keep the shifted partial remainder from overflowing
  // when the divisor is close to full scale.
  localparam int REM_BITS = `DIV_BITS + 2;

  div_state_t                  state;
  count_t                      num_bits;
  count_t                      num_bits_w;
  logic signed [REM_BITS-1:0]  int_remainder;
  logic signed [REM_BITS-1:0]  divisor_ext;

  // Number of significant bits in the value, zero for a zero value.
  function automatic count_t sig_bits(input operand_t value);
    count_t n;
    n = '0;
    for (int i = 0; i < `DIV_BITS; i++) begin
      if (value[i]) begin
        n = count_t'(i + 1);
      end
    end
    return n;
  endfunction

  assign num_bits_w  = sig_bits(dividend);
  assign divisor_ext = $signed({2'b00, divisor});

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        IDLE: begin
          if (start) begin
            state <= INIT;
          end
        end

        INIT: begin
          int_remainder <= '0;
          num_bits      <= num_bits_w;
          if (num_bits_w == '0) begin
            // Nothing to iterate over, the answer is zero.
            quotient <= '0;
            state    <= DIV_DONE;
          end else begin
            quotient <= dividend << (`DIV_BITS - num_bits_w);
            state    <= LEFT_SHIFT;
          end
        end

        LEFT_SHIFT: begin
          {int_remainder, quotient} <= {int_remainder, quotient} << 1;
          if (int_remainder[REM_BITS-1]) begin
            state <= ADJ_ADD;
          end else begin
            state <= ADJ_SUB;
          end
        end

        ADJ_ADD: begin
          int_remainder <= int_remainder + divisor_ext;
          state         <= UPDATE_QUOTIENT;
        end

        ADJ_SUB: begin
          int_remainder <= int_remainder - divisor_ext;
          state         <= UPDATE_QUOTIENT;
        end

        UPDATE_QUOTIENT: begin
          quotient[0] <= ~int_remainder[REM_BITS-1];
          num_bits    <= num_bits - 1'b1;
          state       <= TEST_N;
        end

        TEST_N: begin
          if (|num_bits) begin
            state <= LEFT_SHIFT;
          end else begin
            state <= TEST_REMAINDER;
          end
        end

        TEST_REMAINDER: begin
          if (int_remainder[REM_BITS-1]) begin
            state <= ADJ_FINAL;
          end else begin
            state <= DIV_DONE;
          end
        end

        // A negative remainder gets one restoring add.
        ADJ_FINAL: begin
          int_remainder <= int_remainder + divisor_ext;
          state         <= DIV_DONE;
        end

        DIV_DONE: begin
          done  <= 1'b1;
          state <= IDLE;
        end

        default: state <= IDLE;
      endcase
    end
  end

  assign remainder = int_remainder[`DIV_BITS-1:0];

endmodule

// ==== common/result_wr_if.sv ====
`timescale 1ns/1ns

interface result_wr_if;

  import div_pkg::*;

  logic     request;
  logic     grant;
  tag_t     tag;
  operand_t quotient;
  operand_t remainder;

  // The lane holds request and data until it sees grant.
  modport lane (
    output request,
    output tag,
    output quotient,
    output remainder,
    input  grant
  );

  modport arbiter (
    input  request,
    input  tag,
    input  quotient,
    input  remainder,
    output grant
  );

endinterface

// ==== common/div_pkg.sv ====
package div_pkg;

  `include "div_defs.svh"

  typedef logic [`DIV_BITS-1:0] operand_t;

  typedef logic [`DIV_TAG_BITS-1:0] tag_t;

  // Remaining bit count of a division, wide enough to hold DIV_BITS itself.
  typedef logic [$clog2(`DIV_BITS):0] count_t;

  typedef logic lane_t;

  typedef enum logic [3:0] {
    IDLE,
    INIT,
    LEFT_SHIFT,
    ADJ_ADD,
    ADJ_SUB,
    UPDATE_QUOTIENT,
    TEST_N,
    TEST_REMAINDER,
    ADJ_FINAL,
    DIV_DONE
  } div_state_t;

endpackage

// ==== common/div_defs.svh ====
`ifndef DIV_DEFS_SVH
`define DIV_DEFS_SVH

// Operand width for dividend, divisor, quotient and remainder.
`define DIV_BITS 16

// Tag width, which sets the number of result store entries.
`define DIV_TAG_BITS 4

`endif
